/* hw/mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

//////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////

// Words per cache line
`define MEM_LINE_WORDS 8

// Word offset within a line
`define MEM_OFFSET_BITS 3

// Line index for 16 lines per cache
`define MEM_INDEX_BITS 4

// Whatever is left of the 30-bit word address
`define MEM_TAG_BITS 23

//////////////////////////////////////////////////
// Block store timing and depth
//////////////////////////////////////////////////

`define MEM_RAM_LATENCY 6
`define MEM_RAM_BLOCKS 64

`endif

/* hw/mem_pkg.sv */
package mem_pkg;

`include "mem_config.svh"

    // Data and address words
    typedef logic [31:0] word_t;
    typedef logic [29:0] word_addr_t;

    // One full cache line
    typedef logic [`MEM_LINE_WORDS*32-1:0] block_t;

    // Bit n enables byte n
    typedef logic [3:0] byte_en_t;

    // Address fields
    typedef logic [`MEM_TAG_BITS-1:0]    tag_t;
    typedef logic [`MEM_INDEX_BITS-1:0]  index_t;
    typedef logic [`MEM_OFFSET_BITS-1:0] offset_t;

    // Tag above index as sent to the block store
    typedef logic [`MEM_TAG_BITS+`MEM_INDEX_BITS-1:0] block_addr_t;

    // Cache manager FSM
    typedef enum logic [1:0] {
        CM_IDLE,
        CM_WRITE_BACK,
        CM_FILL_DATA,
        CM_FILL_INSTR
    } cm_state_t;

endpackage

/* hw/cache_store.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module cache_store (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::index_t   index,
    input  mem_pkg::tag_t     tag,
    input  mem_pkg::offset_t  offset,
    input  logic              fill,
    input  mem_pkg::block_t   fill_block,
    input  logic              word_write,
    input  mem_pkg::word_t    write_word,
    input  mem_pkg::byte_en_t byte_en,
    output logic              hit,
    output mem_pkg::word_t    read_word,
    output logic              victim_dirty,
    output mem_pkg::tag_t     victim_tag,
    output mem_pkg::block_t   victim_block
);

    localparam int unsigned LINES  = 1 << `MEM_INDEX_BITS;
    localparam int unsigned WORD_W = 32;

    // Per-line state bits
    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;

    // Tag and data arrays
    mem_pkg::tag_t   tag_q  [LINES];
    mem_pkg::block_t data_q [LINES];

    mem_pkg::block_t cur_line;
    mem_pkg::block_t line_next;

    //////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////

    assign cur_line = data_q[index];

    // A line whose valid bit is clear never hits, whatever its tag holds
    assign hit       = valid_q[index] && (tag_q[index] == tag);
    assign read_word = cur_line[offset*WORD_W +: WORD_W];

    // Line that a miss at this index would replace
    assign victim_dirty = valid_q[index] && dirty_q[index];
    assign victim_tag   = tag_q[index];
    assign victim_block = cur_line;

    //////////////////////////////////////////////////
    // Update
    //////////////////////////////////////////////////

    // Fill replaces the whole line, otherwise merge enabled bytes
    always_comb begin
        line_next = cur_line;
        if (fill) begin
            line_next = fill_block;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    line_next[offset*WORD_W + b*8 +: 8] = write_word[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[index] <= tag;
        end
        if (fill || word_write) begin
            data_q[index] <= line_next;
        end
    end

    // Fresh line is clean; any word write marks it dirty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
        end else if (word_write) begin
            dirty_q[index] <= 1'b1;
        end
    end

endmodule

/* hw/cache_manage_unit.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module cache_manage_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mem_pkg::word_addr_t  ic_addr,
    input  logic                 dmem_read_in,
    input  logic                 dmem_write_in,
    input  mem_pkg::word_addr_t  dmem_addr,
    input  mem_pkg::word_t       data_from_reg,
    input  mem_pkg::byte_en_t    dc_byte_w_en,
    input  logic                 ram_rdy,
    input  mem_pkg::block_t      ram_rdata,
    output logic                 mem_stall,
    output mem_pkg::word_t       ic_data_out,
    output mem_pkg::word_t       dmem_data_out,
    output logic                 ram_en,
    output logic                 ram_write,
    output mem_pkg::block_addr_t ram_addr,
    output mem_pkg::block_t      ram_wdata
);

    localparam int unsigned IDX_LSB = `MEM_OFFSET_BITS;
    localparam int unsigned TAG_LSB = `MEM_OFFSET_BITS + `MEM_INDEX_BITS;

    // Address fields of both streams
    mem_pkg::tag_t    ic_tag;
    mem_pkg::index_t  ic_index;
    mem_pkg::offset_t ic_offset;
    mem_pkg::tag_t    dc_tag;
    mem_pkg::index_t  dc_index;
    mem_pkg::offset_t dc_offset;

    logic ic_hit;
    logic dc_hit;
    logic ic_fill;
    logic dc_fill;
    logic dc_word_write;

    logic            dc_victim_dirty;
    mem_pkg::tag_t   dc_victim_tag;
    mem_pkg::block_t dc_victim_block;

    logic dc_req;
    logic ic_miss;
    logic dc_miss;

    mem_pkg::cm_state_t   state;
    mem_pkg::cm_state_t   state_nxt;
    logic                 ram_en_nxt;
    logic                 ram_write_nxt;
    logic                 addr_load;
    mem_pkg::block_addr_t addr_nxt;
    logic                 wdata_load;

    //////////////////////////////////////////////////
    // Address split and hit/miss
    //////////////////////////////////////////////////

    assign ic_offset = ic_addr[0 +: `MEM_OFFSET_BITS];
    assign ic_index  = ic_addr[IDX_LSB +: `MEM_INDEX_BITS];
    assign ic_tag    = ic_addr[TAG_LSB +: `MEM_TAG_BITS];
    assign dc_offset = dmem_addr[0 +: `MEM_OFFSET_BITS];
    assign dc_index  = dmem_addr[IDX_LSB +: `MEM_INDEX_BITS];
    assign dc_tag    = dmem_addr[TAG_LSB +: `MEM_TAG_BITS];

    assign dc_req  = dmem_read_in || dmem_write_in;
    assign ic_miss = !ic_hit;
    assign dc_miss = dc_req && !dc_hit;

    // Held high until the missing line is resident
    assign mem_stall = ic_miss || dc_miss;

    // Write lands only in the cycle that completes the access
    assign dc_word_write = dmem_write_in && dc_hit && !mem_stall;

    // Line loads on the ready pulse of its own fill
    assign dc_fill = (state == mem_pkg::CM_FILL_DATA) && ram_rdy;
    assign ic_fill = (state == mem_pkg::CM_FILL_INSTR) && ram_rdy;

    cache_store u_icache (
        .clk          ( clk         ),
        .rst_n        ( rst_n       ),
        .index        ( ic_index    ),
        .tag          ( ic_tag      ),
        .offset       ( ic_offset   ),
        .fill         ( ic_fill     ),
        .fill_block   ( ram_rdata   ),
        .word_write   ( 1'b0        ),
        .write_word   ( '0          ),
        .byte_en      ( '0          ),
        .hit          ( ic_hit      ),
        .read_word    ( ic_data_out ),
        .victim_dirty (             ),
        .victim_tag   (             ),
        .victim_block (             )
    );

    cache_store u_dcache (
        .clk          ( clk             ),
        .rst_n        ( rst_n           ),
        .index        ( dc_index        ),
        .tag          ( dc_tag          ),
        .offset       ( dc_offset       ),
        .fill         ( dc_fill         ),
        .fill_block   ( ram_rdata       ),
        .word_write   ( dc_word_write   ),
        .write_word   ( data_from_reg   ),
        .byte_en      ( dc_byte_w_en    ),
        .hit          ( dc_hit          ),
        .read_word    ( dmem_data_out   ),
        .victim_dirty ( dc_victim_dirty ),
        .victim_tag   ( dc_victim_tag   ),
        .victim_block ( dc_victim_block )
    );

    //////////////////////////////////////////////////
    // Write-back and refill FSM
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt     = state;
        ram_en_nxt    = ram_en;
        ram_write_nxt = ram_write;
        addr_load     = 1'b0;
        addr_nxt      = {dc_tag, dc_index};
        wdata_load    = 1'b0;
        case (state)
            mem_pkg::CM_IDLE: begin
                // Data side goes first when both miss
                if (dc_miss) begin
                    ram_en_nxt = 1'b1;
                    addr_load  = 1'b1;
                    if (dc_victim_dirty) begin
                        state_nxt     = mem_pkg::CM_WRITE_BACK;
                        ram_write_nxt = 1'b1;
                        addr_nxt      = {dc_victim_tag, dc_index};
                        wdata_load    = 1'b1;
                    end else begin
                        state_nxt     = mem_pkg::CM_FILL_DATA;
                        ram_write_nxt = 1'b0;
                    end
                end else if (ic_miss) begin
                    state_nxt     = mem_pkg::CM_FILL_INSTR;
                    ram_en_nxt    = 1'b1;
                    ram_write_nxt = 1'b0;
                    addr_load     = 1'b1;
                    addr_nxt      = {ic_tag, ic_index};
                end
            end
            mem_pkg::CM_WRITE_BACK: begin
                if (ram_rdy) begin
                    state_nxt     = mem_pkg::CM_FILL_DATA;
                    ram_en_nxt    = 1'b0;
                    ram_write_nxt = 1'b0;
                end
            end
            mem_pkg::CM_FILL_DATA: begin
                // After a write-back, ram_en is low for one cycle before the read
                if (!ram_en) begin
                    ram_en_nxt = 1'b1;
                    addr_load  = 1'b1;
                end else if (ram_rdy) begin
                    state_nxt  = mem_pkg::CM_IDLE;
                    ram_en_nxt = 1'b0;
                end
            end
            mem_pkg::CM_FILL_INSTR: begin
                if (ram_rdy) begin
                    state_nxt  = mem_pkg::CM_IDLE;
                    ram_en_nxt = 1'b0;
                end
            end
            default: begin
                state_nxt  = mem_pkg::CM_IDLE;
                ram_en_nxt = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= mem_pkg::CM_IDLE;
            ram_en    <= 1'b0;
            ram_write <= 1'b0;
        end else begin
            state     <= state_nxt;
            ram_en    <= ram_en_nxt;
            ram_write <= ram_write_nxt;
        end
    end

    // Request payload held steady while ram_en is high
    always_ff @(posedge clk) begin
        if (addr_load) begin
            ram_addr <= addr_nxt;
        end
        if (wdata_load) begin
            ram_wdata <= dc_victim_block;
        end
    end

endmodule

/* hw/block_store.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module block_store (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ram_en,
    input  logic                 ram_write,
    input  mem_pkg::block_addr_t ram_addr,
    input  mem_pkg::block_t      ram_wdata,
    output logic                 ram_rdy,
    output mem_pkg::block_t      ram_rdata
);

    localparam int unsigned SLOT_BITS = $clog2(`MEM_RAM_BLOCKS);
    localparam int unsigned CNT_BITS  = $clog2(`MEM_RAM_LATENCY + 1);

    mem_pkg::block_t blocks [`MEM_RAM_BLOCKS];

    logic [SLOT_BITS-1:0] slot;
    logic                 ram_en_q;
    logic                 busy;
    logic [CNT_BITS-1:0]  cnt;
    logic                 start;
    logic                 done;

    // Only the low block address bits select a slot
    assign slot = ram_addr[SLOT_BITS-1:0];

    // New request on the rising edge of ram_en
    assign start = ram_en && !ram_en_q;

    // Last waiting cycle; ram_rdy follows on the next one
    assign done = busy && (cnt == CNT_BITS'(`MEM_RAM_LATENCY - 1));

    //////////////////////////////////////////////////
    // Latency counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_en_q <= 1'b0;
            busy     <= 1'b0;
            cnt      <= '0;
            ram_rdy  <= 1'b0;
        end else begin
            ram_en_q <= ram_en;
            ram_rdy  <= done;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_BITS'(1);
            end else if (done) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    // Read data lines up with the ready pulse, writes land at its end
    always_ff @(posedge clk) begin
        if (done && !ram_write) begin
            ram_rdata <= blocks[slot];
        end
        if (ram_rdy && ram_write) begin
            blocks[slot] <= ram_wdata;
        end
    end

endmodule

/* hw/cpu_interface.sv */
`timescale 1ns/1ps

module cpu_interface (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_pkg::word_addr_t ic_addr,
    input  logic                dmem_read_in,
    input  logic                dmem_write_in,
    input  mem_pkg::word_addr_t dmem_addr,
    input  mem_pkg::word_t      data_from_reg,
    input  mem_pkg::byte_en_t   dc_byte_w_en,
    output mem_pkg::word_t      ic_data_out,
    output mem_pkg::word_t      dmem_data_out,
    output logic                mem_stall
);

    // Block transfer between manager and store
    logic                 ram_en;
    logic                 ram_write;
    logic                 ram_rdy;
    mem_pkg::block_addr_t ram_addr;
    mem_pkg::block_t      ram_wdata;
    mem_pkg::block_t      ram_rdata;

    cache_manage_unit u_cm_0 (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .ic_addr       ( ic_addr       ),
        .dmem_read_in  ( dmem_read_in  ),
        .dmem_write_in ( dmem_write_in ),
        .dmem_addr     ( dmem_addr     ),
        .data_from_reg ( data_from_reg ),
        .dc_byte_w_en  ( dc_byte_w_en  ),
        .ram_rdy       ( ram_rdy       ),
        .ram_rdata     ( ram_rdata     ),
        .mem_stall     ( mem_stall     ),
        .ic_data_out   ( ic_data_out   ),
        .dmem_data_out ( dmem_data_out ),
        .ram_en        ( ram_en        ),
        .ram_write     ( ram_write     ),
        .ram_addr      ( ram_addr      ),
        .ram_wdata     ( ram_wdata     )
    );

    // Fixed-latency stand-in for the external memory
    block_store u_store_0 (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .ram_en    ( ram_en    ),
        .ram_write ( ram_write ),
        .ram_addr  ( ram_addr  ),
        .ram_wdata ( ram_wdata ),
        .ram_rdy   ( ram_rdy   ),
        .ram_rdata ( ram_rdata )
    );

endmodule

/* test/cpu_interface_checker.sv */
`timescale 1ns/1ps

module cpu_interface_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_pkg::word_addr_t ic_addr,
    input  logic                dmem_read_in,
    input  logic                dmem_write_in,
    input  mem_pkg::word_addr_t dmem_addr,
    input  mem_pkg::word_t      data_from_reg,
    input  mem_pkg::byte_en_t   dc_byte_w_en,
    input  mem_pkg::word_t      ic_data_out,
    input  mem_pkg::word_t      dmem_data_out,
    input  logic                mem_stall,
    input  logic                step_active,
    input  logic                fetch_step,
    input  logic [7:0]          exp_stall,
    input  logic [159:0]        test_name,
    output int                  test_count,
    output int                  check_count,
    output int                  error_count
);

    // Memory contents as the CPU should see them
    mem_pkg::word_t shadow [mem_pkg::word_addr_t];

    int stall_cycles;
    int step_errors;

    // Only the enabled bytes of the new word replace the old ones
    function automatic mem_pkg::word_t merge_bytes(mem_pkg::word_t old_word,
            mem_pkg::word_t new_word, mem_pkg::byte_en_t ben);
        mem_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (ben[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic compare_word(string sig, mem_pkg::word_addr_t addr, mem_pkg::word_t got);
        check_count++;
        if (!shadow.exists(addr)) begin
            step_errors++;
            $display("test %s reads word 0x%08h, which was never written", test_name, addr);
        end else if (got !== shadow[addr]) begin
            step_errors++;
            $display("** Error %s: %s = 0x%08h, expected 0x%08h",
                     test_name, sig, got, shadow[addr]);
        end
    endtask

    //////////////////////////////////////////////////
    // One completed access per cycle with mem_stall low
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            test_count   = 0;
            check_count  = 0;
            error_count  = 0;
            stall_cycles = 0;
        end else if (step_active) begin
            if (mem_stall) begin
                stall_cycles++;
            end else begin
                step_errors = 0;
                check_count++;
                if (stall_cycles != int'(exp_stall)) begin
                    step_errors++;
                    $display("** Error %s: mem_stall high for 0x%0h cycles, expected 0x%0h",
                             test_name, stall_cycles, exp_stall);
                end
                if (dmem_read_in) begin
                    compare_word("dmem_data_out", dmem_addr, dmem_data_out);
                end
                if (fetch_step) begin
                    compare_word("ic_data_out", ic_addr, ic_data_out);
                end
                // Write lands at the edge that ends this cycle
                if (dmem_write_in) begin
                    shadow[dmem_addr] = merge_bytes(
                        shadow.exists(dmem_addr) ? shadow[dmem_addr] : 'x,
                        data_from_reg, dc_byte_w_en);
                end
                if (step_errors == 0) begin
                    $display("test %s passed", test_name);
                end else begin
                    $display("test %s failed with %0d errors", test_name, step_errors);
                end
                error_count  += step_errors;
                test_count++;
                stall_cycles = 0;
            end
        end
    end

endmodule

/* test/tb_cpu_interface.sv */
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_cpu_interface;

    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 2;
    localparam int NUM_STEPS   = 20;
    localparam int MISS_CYCLES = `MEM_RAM_LATENCY + 2;
    localparam int WATCHDOG_NS = (NUM_STEPS * (2 * MISS_CYCLES + 4) + RST_CYCLES)
                                 * CLK_PERIOD;

    // Data-only steps fetch from a block that is never written
    localparam mem_pkg::word_addr_t IDLE_IA = 30'h3F8;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_FETCH,
        OP_BOTH
    } op_t;

    // xfers is the number of block transfers the step should cost
    typedef struct packed {
        op_t                 op;
        mem_pkg::word_addr_t daddr;
        mem_pkg::word_addr_t iaddr;
        mem_pkg::word_t      wdata;
        mem_pkg::byte_en_t   ben;
        logic [1:0]          xfers;
        logic [159:0]        name;
    } step_t;

    logic                clk;
    logic                rst_n;
    mem_pkg::word_addr_t ic_addr;
    logic                dmem_read_in;
    logic                dmem_write_in;
    mem_pkg::word_addr_t dmem_addr;
    mem_pkg::word_t      data_from_reg;
    mem_pkg::byte_en_t   dc_byte_w_en;
    mem_pkg::word_t      ic_data_out;
    mem_pkg::word_t      dmem_data_out;
    logic                mem_stall;

    logic         step_active;
    logic         fetch_step;
    logic [7:0]   exp_stall;
    logic [159:0] test_name;
    int           test_count;
    int           check_count;
    int           error_count;

    step_t steps [NUM_STEPS];

    cpu_interface cpu_interface_inst (.*);

    cpu_interface_checker checker_inst (.*);

    function automatic step_t entry(op_t op, mem_pkg::word_addr_t daddr,
            mem_pkg::word_addr_t iaddr, mem_pkg::word_t wdata, mem_pkg::byte_en_t ben,
            int xfers, logic [159:0] name);
        return '{op, daddr, iaddr, wdata, ben, 2'(xfers), name};
    endfunction

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    // 0x10 and 0x90 share data index 2, 0x28 and 0xA8 share index 5
    task automatic load_table();
        steps[0]  = entry(OP_WRITE, 30'h010, IDLE_IA, 32'h1234_5678, 4'hF, 1, "b1_write_miss");
        steps[1]  = entry(OP_READ,  30'h010, IDLE_IA, 32'h0, 4'h0, 0, "b1_read_hit");
        steps[2]  = entry(OP_WRITE, 30'h011, IDLE_IA, 32'hCAFE_F00D, 4'hF, 0, "b2_write_full");
        steps[3]  = entry(OP_WRITE, 30'h011, IDLE_IA, 32'h1122_3344, 4'h5, 0, "b2_write_bytes");
        steps[4]  = entry(OP_READ,  30'h011, IDLE_IA, 32'h0, 4'h0, 0, "b2_read_merge");
        steps[5]  = entry(OP_WRITE, 30'h092, IDLE_IA, 32'hDEAD_BEEF, 4'hF, 2, "b3_write_conflict");
        steps[6]  = entry(OP_READ,  30'h010, IDLE_IA, 32'h0, 4'h0, 2, "b3_read_evicted");
        steps[7]  = entry(OP_READ,  30'h011, IDLE_IA, 32'h0, 4'h0, 0, "b3_read_hit");
        steps[8]  = entry(OP_READ,  30'h092, IDLE_IA, 32'h0, 4'h0, 1, "b3_read_back");
        steps[9]  = entry(OP_WRITE, 30'h028, IDLE_IA, 32'h0BAD_C0DE, 4'hF, 1, "b4_write_c0");
        steps[10] = entry(OP_WRITE, 30'h02B, IDLE_IA, 32'h600D_F00D, 4'hF, 0, "b4_write_c3");
        steps[11] = entry(OP_WRITE, 30'h0A8, IDLE_IA, 32'hA5A5_5A5A, 4'hF, 2, "b4_write_evict");
        steps[12] = entry(OP_FETCH, 30'h000, 30'h010, 32'h0, 4'h0, 1, "b4_fetch_a0");
        steps[13] = entry(OP_FETCH, 30'h000, 30'h011, 32'h0, 4'h0, 0, "b4_fetch_a1");
        steps[14] = entry(OP_FETCH, 30'h000, 30'h092, 32'h0, 4'h0, 1, "b4_fetch_b");
        steps[15] = entry(OP_FETCH, 30'h000, 30'h028, 32'h0, 4'h0, 1, "b4_fetch_c0");
        steps[16] = entry(OP_FETCH, 30'h000, 30'h02B, 32'h0, 4'h0, 0, "b4_fetch_c3");
        // Data fill first, then the instruction fill
        steps[17] = entry(OP_BOTH,  30'h011, 30'h010, 32'h0, 4'h0, 2, "b5_both_clean");
        steps[18] = entry(OP_BOTH,  30'h028, 30'h0A8, 32'h0, 4'h0, 3, "b5_both_dirty");
        steps[19] = entry(OP_READ,  30'h0A8, IDLE_IA, 32'h0, 4'h0, 1, "b5_read_d");
    endtask

    task automatic apply_step(step_t s);
        dmem_read_in  = (s.op == OP_READ) || (s.op == OP_BOTH);
        dmem_write_in = (s.op == OP_WRITE);
        dmem_addr     = s.daddr;
        data_from_reg = s.wdata;
        dc_byte_w_en  = s.ben;
        ic_addr       = s.iaddr;
        fetch_step    = (s.op == OP_FETCH) || (s.op == OP_BOTH);
        exp_stall     = 8'(s.xfers * MISS_CYCLES);
        test_name     = s.name;
        step_active   = 1'b1;
    endtask

    // Look at mem_stall mid-cycle and let the completing edge pass
    task automatic wait_ready();
        @(negedge clk);
        while (mem_stall) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n         = 1'b0;
        ic_addr       = IDLE_IA;
        dmem_read_in  = 1'b0;
        dmem_write_in = 1'b0;
        dmem_addr     = '0;
        data_from_reg = '0;
        dc_byte_w_en  = '0;
        step_active   = 1'b0;
        fetch_step    = 1'b0;
        exp_stall     = '0;
        test_name     = '0;
        load_table();
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        // Idle fetch line comes in before the first step
        wait_ready();
        for (int i = 0; i < NUM_STEPS; i++) begin
            #1 apply_step(steps[i]);
            wait_ready();
        end
        #1;
        step_active   = 1'b0;
        fetch_step    = 1'b0;
        dmem_read_in  = 1'b0;
        dmem_write_in = 1'b0;
        ic_addr       = IDLE_IA;
        repeat (2) @(posedge clk);
        $display("Tests run: %0d of %0d, checks: %0d, errors: %0d",
                 test_count, NUM_STEPS, check_count, error_count);
        if (error_count == 0 && test_count == NUM_STEPS) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the table did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+hw
hw/mem_pkg.sv
hw/cache_store.sv
hw/cache_manage_unit.sv
hw/block_store.sv
hw/cpu_interface.sv
test/cpu_interface_checker.sv
test/tb_cpu_interface.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_cpu_interface \
    -f files.f -o sim_cpu_interface || exit 1

sim_out="$(./obj_dir/sim_cpu_interface)"
echo "$sim_out"
echo "$sim_out" | grep -q "Verification passed" && exit 0 || exit 1
